// ==== verilog.f ====
+incdir+dv
src/nn_pkg.sv
src/nn_neuron.sv
src/nn_sequencer.sv
src/nn_argmax.sv
src/nn_classifier.sv
dv/nn_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the nn_classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module nn_tb -f verilog.f -o sim_nn_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit $status
fi

./obj_dir/sim_nn_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation passed"
exit 0

// ==== dv/nn_ref.svh ====
`ifndef NN_REF_SVH
`define NN_REF_SVH

localparam int FILL_RANDOM = 0;
localparam int FILL_NEG_OUT = 1; // zero output weights, negative output biases
localparam int FILL_SATURATE = 2; // large inputs, non-negative hidden weights
localparam longint ACT_LIMIT = (longint'(1) << (nn_pkg::IN_W - 1)) - 1;

logic [31:0] lfsr_state = 32'hcf14;
logic signed [nn_pkg::IN_W-1:0] in_tab [N_IN];
logic signed [nn_pkg::W_W-1:0] hid_w [N_HIDDEN][N_IN];
logic signed [nn_pkg::W_W-1:0] hid_b [N_HIDDEN];
logic signed [nn_pkg::W_W-1:0] out_w [N_OUT][N_HIDDEN];
logic signed [nn_pkg::W_W-1:0] out_b [N_OUT];

// galois lfsr, one step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
	end
	return v;
endfunction

function automatic logic signed [nn_pkg::W_W-1:0] rand_weight();
	return nn_pkg::W_W'(rand_bits(nn_pkg::W_W));
endfunction

function automatic void fill_tables(input int mode);
	logic [31:0] r;
	for (int i = 0; i < N_IN; i++) begin
		r = (mode == FILL_SATURATE) ? rand_bits(14) : rand_bits(8);
		in_tab[i] = (mode == FILL_SATURATE) ? {2'b01, r[13:0]} : {{8{r[7]}}, r[7:0]};
	end
	for (int n = 0; n < N_HIDDEN; n++) begin
		for (int i = 0; i < N_IN; i++) begin
			r = (mode == FILL_SATURATE) ? rand_bits(7) : rand_bits(8);
			hid_w[n][i] = (mode == FILL_SATURATE) ? {1'b0, r[6:0]} : r[7:0];
		end
		hid_b[n] = rand_weight();
	end
	for (int n = 0; n < N_OUT; n++) begin
		for (int j = 0; j < N_HIDDEN; j++) begin
			out_w[n][j] = (mode == FILL_NEG_OUT) ? '0 : rand_weight();
		end
		r = (mode == FILL_NEG_OUT) ? rand_bits(7) : rand_bits(8);
		out_b[n] = (mode == FILL_NEG_OUT) ? {1'b1, r[6:0]} : r[7:0];
	end
endfunction

// expected class index from the layer rules
function automatic int classify();
	longint h [N_HIDDEN];
	longint acc;
	longint best;
	int best_idx;
	for (int n = 0; n < N_HIDDEN; n++) begin
		acc = longint'(hid_b[n]);
		for (int i = 0; i < N_IN; i++) begin
			acc = acc + longint'(hid_w[n][i]) * longint'(in_tab[i]);
		end
		h[n] = (acc < 0) ? 0 : ((acc > ACT_LIMIT) ? ACT_LIMIT : acc); // relu, then clip
	end
	best = 0;
	best_idx = 0;
	for (int k = 0; k < N_OUT; k++) begin
		acc = longint'(out_b[k]);
		for (int j = 0; j < N_HIDDEN; j++) begin
			acc = acc + longint'(out_w[k][j]) * h[j];
		end
		if (acc > best) begin // negatives never beat the starting 0
			best = acc;
			best_idx = k;
		end
	end
	return best_idx;
endfunction

`endif

// ==== dv/nn_tb.sv ====
`default_nettype none

module nn_tb;

	localparam int N_IN = 8;
	localparam int N_HIDDEN = 6;
	localparam int N_OUT = 4;
	localparam int N_READS = N_IN + N_HIDDEN * (N_IN + 1) + N_OUT * (N_HIDDEN + 1);
	localparam int RUN_TIMEOUT = 4000; // cycles

	logic clk = 1'b0;
	logic rst;
	logic start;
	nn_pkg::mem_req_t mem_req;
	nn_pkg::mem_rsp_t mem_rsp;
	logic [nn_pkg::IDX_W-1:0] result;
	logic finished;
	int read_cnt = 0;
	int read_base = 0;
	int fin_cnt = 0;
	nn_pkg::mem_req_t exp_req [$];
	int exp_lat [$];

	`include "nn_ref.svh"

	nn_classifier #(
		.N_IN(N_IN),
		.N_HIDDEN(N_HIDDEN),
		.N_OUT(N_OUT)
	) i_nn_classifier (
		.clk(clk),
		.rst(rst),
		.start(start),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.result(result),
		.finished(finished)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin
		if (!rst && finished) begin
			fin_cnt <= fin_cnt + 1;
		end
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input longint got, input longint exp);
		if (got != exp) begin
			stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// inputs first, then per layer all weight rows followed by all biases
	function automatic void build_requests();
		nn_pkg::mem_req_t r;
		exp_req.delete();
		exp_lat.delete();
		r = '0;
		r.kind = nn_pkg::KIND_INPUT;
		for (int i = 0; i < N_IN; i++) begin
			r.index = nn_pkg::IDX_W'(i);
			exp_req.push_back(r);
		end
		r.kind = nn_pkg::KIND_PARAM;
		for (int l = 0; l < 2; l++) begin
			r.layer = (l == 0) ? nn_pkg::LAYER_HIDDEN : nn_pkg::LAYER_OUT;
			for (int n = 0; n < ((l == 0) ? N_HIDDEN : N_OUT); n++) begin
				for (int i = 1; i <= ((l == 0) ? N_IN : N_HIDDEN); i++) begin
					r.neuron = nn_pkg::IDX_W'(n);
					r.index = nn_pkg::IDX_W'(i);
					exp_req.push_back(r);
				end
			end
			for (int n = 0; n < ((l == 0) ? N_HIDDEN : N_OUT); n++) begin
				r.neuron = nn_pkg::IDX_W'(n);
				r.index = '0;
				exp_req.push_back(r);
			end
		end
		for (int i = 0; i < exp_req.size(); i++) begin
			exp_lat.push_back(1 + int'(rand_bits(2))); // 1 to 4 cycles
		end
	endfunction

	function automatic nn_pkg::mem_rsp_t memory_word(input nn_pkg::mem_req_t r);
		nn_pkg::mem_rsp_t rsp;
		rsp = '0;
		rsp.rd_done = 1'b1;
		if (r.kind == nn_pkg::KIND_INPUT) begin
			rsp.act_data = in_tab[r.index];
		end else if (r.layer == nn_pkg::LAYER_HIDDEN) begin
			rsp.param_data = (r.index == '0) ? hid_b[r.neuron] : hid_w[r.neuron][r.index - 1];
		end else begin
			rsp.param_data = (r.index == '0) ? out_b[r.neuron] : out_w[r.neuron][r.index - 1];
		end
		return rsp;
	endfunction

	// memory model, one read in flight
	initial begin
		int pos;
		nn_pkg::mem_rsp_t rsp;
		mem_rsp = '0;
		forever begin
			@(negedge clk);
			if (!rst && mem_req.rd_start) begin
				pos = read_cnt - read_base;
				if (pos >= exp_req.size()) begin
					stop_on_error("memory read issued beyond the expected number of reads");
				end else begin
					check_value("mem_req.kind", longint'(mem_req.kind), longint'(exp_req[pos].kind));
					check_value("mem_req.index", longint'(mem_req.index), longint'(exp_req[pos].index));
					if (exp_req[pos].kind == nn_pkg::KIND_PARAM) begin
						check_value("mem_req.layer", longint'(mem_req.layer),
							longint'(exp_req[pos].layer));
						check_value("mem_req.neuron", longint'(mem_req.neuron),
							longint'(exp_req[pos].neuron));
					end
					rsp = memory_word(mem_req);
					read_cnt = read_cnt + 1;
					repeat (exp_lat[pos]) @(posedge clk);
					mem_rsp <= rsp;
					@(posedge clk);
					mem_rsp <= '0;
				end
			end
		end
	end

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_once(input int mode, input logic second_start);
		int cnt;
		int exp_res;
		int fin_base;
		fill_tables(mode);
		build_requests();
		exp_res = classify();
		read_base = read_cnt;
		fin_base = fin_cnt;
		pulse_start();
		cnt = 0;
		while (second_start && (read_cnt - read_base < N_READS / 2)) begin
			@(negedge clk);
			cnt++;
			if (cnt > RUN_TIMEOUT) begin
				stop_on_error("timed out waiting for reads before the second start pulse");
			end
		end
		if (second_start) begin
			pulse_start(); // lands mid-run
		end
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
			if (cnt > RUN_TIMEOUT) begin
				stop_on_error("timed out waiting for finished");
			end
		end while (!finished);
		check_value("result", longint'(result), longint'(exp_res));
		if (mode == FILL_NEG_OUT) begin
			check_value("result", longint'(result), 0);
		end
		repeat (N_OUT + 8) @(negedge clk); // sequencer drains back to idle
		check_value("read_cnt", longint'(read_cnt - read_base), longint'(N_READS));
		check_value("fin_cnt", longint'(fin_cnt - fin_base), 1);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_value("finished", longint'(finished), 0);
			check_value("result", longint'(result), 0);
			check_value("mem_req.rd_start", longint'(mem_req.rd_start), 0);
		end
		for (int i = 0; i < 20; i++) begin
			run_once(FILL_RANDOM, 1'b0);
		end
		run_once(FILL_NEG_OUT, 1'b0);
		for (int i = 0; i < 3; i++) begin
			run_once(FILL_SATURATE, 1'b0);
		end
		run_once(FILL_RANDOM, 1'b1);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/nn_classifier.sv ====
`default_nettype none

module nn_classifier #(
	parameter int N_IN = 8,
	parameter int N_HIDDEN = 6,
	parameter int N_OUT = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output nn_pkg::mem_req_t mem_req,
	input wire nn_pkg::mem_rsp_t mem_rsp,
	output logic [nn_pkg::IDX_W-1:0] result,
	output logic finished
);

	logic [nn_pkg::IN_W-1:0] act_vec [N_IN];
	logic relu_en;
	nn_pkg::param_wr_t param_wr;
	logic [N_HIDDEN-1:0] wr_en;
	logic signed [nn_pkg::ACC_W-1:0] neuron_out [N_HIDDEN];
	logic signed [nn_pkg::ACC_W-1:0] class_out [N_OUT];
	logic scan_start;

	nn_sequencer #(
		.N_IN(N_IN),
		.N_HIDDEN(N_HIDDEN),
		.N_OUT(N_OUT)
	) i_nn_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.act_vec(act_vec),
		.relu_en(relu_en),
		.param_wr(param_wr),
		.wr_en(wr_en),
		.neuron_out(neuron_out),
		.scan_start(scan_start)
	);

	// one array serves both layers
	for (genvar g = 0; g < N_HIDDEN; g++) begin : g_neuron
		nn_neuron #(
			.N_IN(N_IN)
		) i_nn_neuron (
			.clk(clk),
			.rst(rst),
			.act_vec(act_vec),
			.relu_en(relu_en),
			.param_wr(param_wr),
			.wr_en(wr_en[g]),
			.out(neuron_out[g])
		);
	end

	// the output layer lives in the first N_OUT neurons
	for (genvar g = 0; g < N_OUT; g++) begin : g_class
		assign class_out[g] = neuron_out[g];
	end

	nn_argmax #(
		.N_OUT(N_OUT)
	) i_nn_argmax (
		.clk(clk),
		.rst(rst),
		.scan_start(scan_start),
		.neuron_out(class_out),
		.result(result),
		.finished(finished)
	);

endmodule

`default_nettype wire

// ==== src/nn_argmax.sv ====
`default_nettype none

module nn_argmax #(
	parameter int N_OUT = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic scan_start,
	input wire logic signed [nn_pkg::ACC_W-1:0] neuron_out [N_OUT],
	output logic [nn_pkg::IDX_W-1:0] result,
	output logic finished
);

	logic busy;
	logic [nn_pkg::IDX_W-1:0] cnt;
	logic signed [nn_pkg::ACC_W-1:0] best_val;
	logic [nn_pkg::IDX_W-1:0] best_idx;
	logic signed [nn_pkg::ACC_W-1:0] cur;
	logic take;

	always_comb begin
		cur = '0;
		for (int i = 0; i < N_OUT; i++) begin
			if (cnt == nn_pkg::IDX_W'(i)) begin
				cur = neuron_out[i];
			end
		end
	end

	// strictly greater, so ties keep the lower class
	assign take = !cur[nn_pkg::ACC_W-1] && (cur > best_val);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			best_val <= '0;
			best_idx <= '0;
			result <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (scan_start && !busy) begin
				busy <= 1'b1;
				cnt <= '0;
				best_val <= '0;
				best_idx <= '0;
			end else if (busy) begin
				if (take) begin
					best_val <= cur;
					best_idx <= cnt;
				end
				if (cnt == nn_pkg::IDX_W'(N_OUT - 1)) begin
					busy <= 1'b0;
					result <= take ? cnt : best_idx;
					finished <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (rst)
		busy |-> cnt < nn_pkg::IDX_W'(N_OUT));

endmodule

`default_nettype wire

// ==== src/nn_sequencer.sv ====
`default_nettype none

module nn_sequencer #(
	parameter int N_IN = 8,
	parameter int N_HIDDEN = 6,
	parameter int N_OUT = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output nn_pkg::mem_req_t mem_req,
	input wire nn_pkg::mem_rsp_t mem_rsp,
	output logic [nn_pkg::IN_W-1:0] act_vec [N_IN],
	output logic relu_en,
	output nn_pkg::param_wr_t param_wr,
	output logic [N_HIDDEN-1:0] wr_en,
	input wire logic signed [nn_pkg::ACC_W-1:0] neuron_out [N_HIDDEN],
	output logic scan_start
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_IN_REQ,
		S_IN_WAIT,
		S_W_REQ,
		S_W_WAIT,
		S_ZERO,
		S_B_REQ,
		S_B_WAIT,
		S_XFER,
		S_SCAN,
		S_DRAIN
	} state_e;

	localparam logic [nn_pkg::IN_W-1:0] ACT_MAX = {1'b0, {(nn_pkg::IN_W-1){1'b1}}};

	state_e state;
	nn_pkg::layer_e layer_q;
	logic [nn_pkg::IDX_W-1:0] idx; // input, weight index or drain count
	logic [nn_pkg::IDX_W-1:0] n_cnt;
	logic [nn_pkg::IDX_W-1:0] n_last;
	logic [nn_pkg::IDX_W-1:0] w_last; // last weight fetched from memory
	logic rd_done;
	logic wr_fire;

	function automatic logic [nn_pkg::IN_W-1:0] sat_act(input logic signed [nn_pkg::ACC_W-1:0] v);
		if (|v[nn_pkg::ACC_W-1:nn_pkg::IN_W-1]) begin
			return ACT_MAX; // clip at largest positive input value
		end
		return v[nn_pkg::IN_W-1:0];
	endfunction

	assign rd_done = mem_rsp.rd_done;
	assign n_last = (layer_q == nn_pkg::LAYER_HIDDEN) ? nn_pkg::IDX_W'(N_HIDDEN - 1)
		: nn_pkg::IDX_W'(N_OUT - 1);
	assign w_last = (layer_q == nn_pkg::LAYER_HIDDEN) ? nn_pkg::IDX_W'(N_IN)
		: nn_pkg::IDX_W'(N_HIDDEN);

	always_comb begin
		mem_req.rd_start = (state == S_IN_REQ) || (state == S_W_REQ) || (state == S_B_REQ);
		mem_req.kind = (state == S_IN_REQ || state == S_IN_WAIT) ? nn_pkg::KIND_INPUT
			: nn_pkg::KIND_PARAM;
		mem_req.layer = layer_q;
		mem_req.neuron = n_cnt;
		mem_req.index = (state == S_B_REQ || state == S_B_WAIT) ? '0 : idx;
	end

	// writes land on the rd_done edge and zero fill takes one slot per cycle
	assign wr_fire = ((state == S_W_WAIT || state == S_B_WAIT) && rd_done) || (state == S_ZERO);
	assign wr_en = N_HIDDEN'(wr_fire) << n_cnt;
	assign param_wr.index = (state == S_B_WAIT) ? '0 : idx;
	assign param_wr.data = (state == S_ZERO) ? '0 : mem_rsp.param_data;

	assign scan_start = (state == S_SCAN);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			layer_q <= nn_pkg::LAYER_HIDDEN;
			idx <= '0;
			n_cnt <= '0;
			relu_en <= 1'b1;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						layer_q <= nn_pkg::LAYER_HIDDEN;
						relu_en <= 1'b1;
						idx <= '0;
						n_cnt <= '0;
						state <= S_IN_REQ;
					end
				end
				S_IN_REQ: state <= S_IN_WAIT;
				S_IN_WAIT: begin
					if (rd_done) begin
						if (idx == nn_pkg::IDX_W'(N_IN - 1)) begin
							idx <= nn_pkg::IDX_W'(1);
							state <= S_W_REQ;
						end else begin
							idx <= idx + 1'b1;
							state <= S_IN_REQ;
						end
					end
				end
				S_W_REQ: state <= S_W_WAIT;
				S_W_WAIT: begin
					if (rd_done) begin
						if (idx != w_last) begin
							idx <= idx + 1'b1;
							state <= S_W_REQ;
						end else if (idx != nn_pkg::IDX_W'(N_IN)) begin
							idx <= idx + 1'b1; // rest of the row is zero
							state <= S_ZERO;
						end else if (n_cnt == n_last) begin
							n_cnt <= '0;
							state <= S_B_REQ;
						end else begin
							n_cnt <= n_cnt + 1'b1;
							idx <= nn_pkg::IDX_W'(1);
							state <= S_W_REQ;
						end
					end
				end
				S_ZERO: begin
					if (idx != nn_pkg::IDX_W'(N_IN)) begin
						idx <= idx + 1'b1;
					end else if (n_cnt == n_last) begin
						n_cnt <= '0;
						state <= S_B_REQ;
					end else begin
						n_cnt <= n_cnt + 1'b1;
						idx <= nn_pkg::IDX_W'(1);
						state <= S_W_REQ;
					end
				end
				S_B_REQ: state <= S_B_WAIT;
				S_B_WAIT: begin
					if (rd_done) begin
						if (n_cnt != n_last) begin
							n_cnt <= n_cnt + 1'b1;
							state <= S_B_REQ;
						end else if (layer_q == nn_pkg::LAYER_HIDDEN) begin
							state <= S_XFER;
						end else begin
							state <= S_SCAN;
						end
					end
				end
				S_XFER: begin
					layer_q <= nn_pkg::LAYER_OUT;
					relu_en <= 1'b0;
					n_cnt <= '0;
					idx <= nn_pkg::IDX_W'(1);
					state <= S_W_REQ;
				end
				S_SCAN: begin
					idx <= '0;
					state <= S_DRAIN;
				end
				S_DRAIN: begin
					// hold the outputs steady until argmax is through
					if (idx == nn_pkg::IDX_W'(N_OUT)) begin
						state <= S_IDLE;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IN_WAIT && rd_done) begin
			for (int i = 0; i < N_IN; i++) begin
				if (idx == nn_pkg::IDX_W'(i)) begin
					act_vec[i] <= mem_rsp.act_data;
				end
			end
		end else if (state == S_XFER) begin
			for (int i = 0; i < N_HIDDEN; i++) begin
				act_vec[i] <= sat_act(neuron_out[i]);
			end
			for (int i = N_HIDDEN; i < N_IN; i++) begin
				act_vec[i] <= '0;
			end
		end
	end

	a_rd_single: assert property (@(posedge clk) disable iff (rst)
		mem_req.rd_start |=> !mem_req.rd_start);

	// a write always reaches exactly one neuron of the array
	a_wr_onehot: assert property (@(posedge clk) disable iff (rst)
		wr_fire |-> $onehot(wr_en));

endmodule

`default_nettype wire

// ==== src/nn_neuron.sv ====
`default_nettype none

module nn_neuron #(
	parameter int N_IN = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [nn_pkg::IN_W-1:0] act_vec [N_IN],
	input wire logic relu_en,
	input wire nn_pkg::param_wr_t param_wr,
	input wire logic wr_en,
	output logic signed [nn_pkg::ACC_W-1:0] out
);

	logic signed [nn_pkg::W_W-1:0] w [N_IN];
	logic signed [nn_pkg::W_W-1:0] bias;
	logic signed [nn_pkg::ACC_W-1:0] acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			bias <= '0;
			for (int i = 0; i < N_IN; i++) begin
				w[i] <= '0;
			end
		end else if (wr_en) begin
			if (param_wr.index == '0) begin
				bias <= param_wr.data;
			end
			for (int i = 0; i < N_IN; i++) begin
				if (param_wr.index == nn_pkg::IDX_W'(i + 1)) begin
					w[i] <= param_wr.data; // weight slot i sits at address i+1
				end
			end
		end
	end

	// dot product settles within the cycle
	always_comb begin
		acc = nn_pkg::ACC_W'(bias);
		for (int i = 0; i < N_IN; i++) begin
			acc = acc + w[i] * $signed(act_vec[i]);
		end
	end

	assign out = (relu_en && acc[nn_pkg::ACC_W-1]) ? '0 : acc; // relu clamps negatives

	// the sequencer never addresses past the last weight
	a_wr_index: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> param_wr.index <= nn_pkg::IDX_W'(N_IN));

endmodule

`default_nettype wire

// ==== src/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

	// datapath widths
	localparam int IN_W = 16; // input and activation word
	localparam int W_W = 8; // signed weight or bias
	localparam int ACC_W = 32; // neuron accumulator and output
	localparam int IDX_W = 8; // neuron and index address fields

	// what a memory read fetches
	typedef enum logic {
		KIND_INPUT,
		KIND_PARAM
	} mem_kind_e;

	// layer field of a parameter read
	typedef enum logic [1:0] {
		LAYER_HIDDEN = 2'd1,
		LAYER_OUT = 2'd2
	} layer_e;

	// request toward the external memory
	typedef struct packed {
		logic rd_start; // one-cycle strobe, fields held afterwards
		mem_kind_e kind;
		layer_e layer;
		logic [IDX_W-1:0] neuron;
		logic [IDX_W-1:0] index; // input number, or 0 bias / 1.. weight
	} mem_req_t;

	// answer from the external memory
	typedef struct packed {
		logic rd_done; // one-cycle pulse, data valid with it
		logic [IN_W-1:0] act_data;
		logic [W_W-1:0] param_data;
	} mem_rsp_t;

	// parameter write broadcast to the neuron array
	typedef struct packed {
		logic [IDX_W-1:0] index; // 0 bias, 1..N_IN weight
		logic [W_W-1:0] data;
	} param_wr_t;

endpackage

`default_nettype wire
